// File: hw/rv32_params.svh
`ifndef RV32_PARAMS_SVH
`define RV32_PARAMS_SVH

// Data path width of the integer core
`define RV32_XLEN 32

// Width of a register file index (x0..x31)
`define RV32_REG_IDX_W 5

// addi x0, x0, 0
`define RV32_NOP 32'h00000013

`endif

// File: hw/rv32_types_pkg.sv
`include "rv32_params.svh"

package rv32_types_pkg;

    // Operands, results, pc and memory addresses
    typedef logic [`RV32_XLEN-1:0] rv32_word;

    // Raw instruction as fetched, always 32 bits for RV32 without C
    typedef logic [31:0] rv32_instr;

    // Register file index
    typedef logic [`RV32_REG_IDX_W-1:0] rv32_reg_idx;

endpackage

// File: hw/rv32_ctrl_pkg.sv
package rv32_ctrl_pkg;

    // Where a source operand comes from
    typedef enum logic [1:0] {
        BYPASS_NONE      = 2'd0,
        BYPASS_EXEC_BUFF = 2'd1,
        BYPASS_MEM_BUFF  = 2'd2
    } bypass_sel_t;

    // Instruction format, selects the immediate layout
    typedef enum logic [2:0] {
        IMM_R = 3'd0,
        IMM_I = 3'd1,
        IMM_S = 3'd2,
        IMM_B = 3'd3,
        IMM_U = 3'd4,
        IMM_J = 3'd5
    } imm_type_t;

    // ALU operand crossbar select
    typedef enum logic [2:0] {
        ALU_IN_ZERO  = 3'd0,
        ALU_IN_REG_1 = 3'd1,
        ALU_IN_REG_2 = 3'd2,
        ALU_IN_PC    = 3'd3,
        ALU_IN_IMM   = 3'd4
    } alu_in_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // Same numbering as funct3[1:0] of the M extension multiplies
    typedef enum logic [1:0] {
        MUL_LO    = 2'd0,
        MUL_HI_SS = 2'd1,
        MUL_HI_SU = 2'd2,
        MUL_HI_UU = 2'd3
    } mul_op_t;

    typedef enum logic [2:0] {
        BR_NONE   = 3'd0,
        BR_EQ     = 3'd1,
        BR_NE     = 3'd2,
        BR_LT     = 3'd3,
        BR_GE     = 3'd4,
        BR_LTU    = 3'd5,
        BR_GEU    = 3'd6,
        BR_ALWAYS = 3'd7
    } branch_op_t;

    // Source of the value written back to the register file
    typedef enum logic [2:0] {
        WB_NONE     = 3'd0,
        WB_PC4      = 3'd1,
        WB_INT_ALU  = 3'd2,
        WB_STORE    = 3'd3,
        WB_MUL_UNIT = 3'd4
    } wb_src_t;

endpackage

// File: hw/rv32_operand_stage.sv
`timescale 1ns/10ps

module rv32_operand_stage (
    input  rv32_types_pkg::rv32_instr    instr,
    input  rv32_types_pkg::rv32_word     pc,
    input  rv32_types_pkg::rv32_word     reg_data1,
    input  rv32_types_pkg::rv32_word     reg_data2,
    input  rv32_types_pkg::rv32_word     exec_bypass,
    input  rv32_types_pkg::rv32_word     wb_bypass,
    input  rv32_ctrl_pkg::bypass_sel_t   bypass_rs1,
    input  rv32_ctrl_pkg::bypass_sel_t   bypass_rs2,
    input  rv32_ctrl_pkg::imm_type_t     imm_type,
    input  rv32_ctrl_pkg::alu_in_t       alu_in1,
    input  rv32_ctrl_pkg::alu_in_t       alu_in2,
    output rv32_types_pkg::rv32_word     op_rs1,
    output rv32_types_pkg::rv32_word     op_rs2,
    output rv32_types_pkg::rv32_word     alu_a,
    output rv32_types_pkg::rv32_word     alu_b
);

    rv32_types_pkg::rv32_word imm;

    function automatic rv32_types_pkg::rv32_word bypass_mux(
        input rv32_ctrl_pkg::bypass_sel_t sel,
        input rv32_types_pkg::rv32_word   reg_val,
        input rv32_types_pkg::rv32_word   exec_val,
        input rv32_types_pkg::rv32_word   wb_val
    );
        case (sel)
            rv32_ctrl_pkg::BYPASS_EXEC_BUFF: return exec_val;
            rv32_ctrl_pkg::BYPASS_MEM_BUFF:  return wb_val;
            default:                         return reg_val;
        endcase
    endfunction

    function automatic rv32_types_pkg::rv32_word xbar_mux(
        input rv32_ctrl_pkg::alu_in_t   sel,
        input rv32_types_pkg::rv32_word rs1,
        input rv32_types_pkg::rv32_word rs2,
        input rv32_types_pkg::rv32_word pc_val,
        input rv32_types_pkg::rv32_word imm_val
    );
        case (sel)
            rv32_ctrl_pkg::ALU_IN_REG_1: return rs1;
            rv32_ctrl_pkg::ALU_IN_REG_2: return rs2;
            rv32_ctrl_pkg::ALU_IN_PC:    return pc_val;
            rv32_ctrl_pkg::ALU_IN_IMM:   return imm_val;
            default:                     return '0;
        endcase
    endfunction

    // Forwarding from the own output register or from write-back
    assign op_rs1 = bypass_mux(bypass_rs1, reg_data1, exec_bypass, wb_bypass);
    assign op_rs2 = bypass_mux(bypass_rs2, reg_data2, exec_bypass, wb_bypass);

    // Immediate decode, sign bit is always instr[31]
    always_comb begin
        case (imm_type)
            rv32_ctrl_pkg::IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            rv32_ctrl_pkg::IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv32_ctrl_pkg::IMM_B: imm = {{19{instr[31]}}, instr[31], instr[7],
                                         instr[30:25], instr[11:8], 1'b0};
            rv32_ctrl_pkg::IMM_U: imm = {instr[31:12], 12'b0};
            rv32_ctrl_pkg::IMM_J: imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                         instr[20], instr[30:21], 1'b0};
            default:              imm = '0;
        endcase
    end

    assign alu_a = xbar_mux(alu_in1, op_rs1, op_rs2, pc, imm);
    assign alu_b = xbar_mux(alu_in2, op_rs1, op_rs2, pc, imm);

endmodule

// File: hw/rv32_int_alu.sv
`timescale 1ns/10ps

module rv32_int_alu (
    input  rv32_types_pkg::rv32_word a,
    input  rv32_types_pkg::rv32_word b,
    input  rv32_ctrl_pkg::alu_op_t   op,
    output rv32_types_pkg::rv32_word result
);

    logic [4:0] shamt;

    // RV32 shifts only look at the low five bits
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv32_ctrl_pkg::ALU_ADD:  result = a + b;
            rv32_ctrl_pkg::ALU_SUB:  result = a - b;
            rv32_ctrl_pkg::ALU_AND:  result = a & b;
            rv32_ctrl_pkg::ALU_OR:   result = a | b;
            rv32_ctrl_pkg::ALU_XOR:  result = a ^ b;
            rv32_ctrl_pkg::ALU_SLL:  result = a << shamt;
            rv32_ctrl_pkg::ALU_SRL:  result = a >> shamt;
            rv32_ctrl_pkg::ALU_SRA:  result = rv32_types_pkg::rv32_word'($signed(a) >>> shamt);
            // Compare result is zero extended to a full word
            rv32_ctrl_pkg::ALU_SLT:  result = rv32_types_pkg::rv32_word'($signed(a) < $signed(b));
            rv32_ctrl_pkg::ALU_SLTU: result = rv32_types_pkg::rv32_word'(a < b);
            default:                 result = '0;
        endcase
    end

endmodule

// File: hw/rv32_mul_unit.sv
`timescale 1ns/10ps
`include "rv32_params.svh"

module rv32_mul_unit (
    input  rv32_types_pkg::rv32_word a,
    input  rv32_types_pkg::rv32_word b,
    input  rv32_ctrl_pkg::mul_op_t   op,
    output rv32_types_pkg::rv32_word result
);

    logic                        a_signed;
    logic                        b_signed;
    logic [`RV32_XLEN:0]         a_ext;
    logic [`RV32_XLEN:0]         b_ext;
    logic signed [2*`RV32_XLEN+1:0] product;

    // mulhsu treats only rs1 as signed
    assign a_signed = (op == rv32_ctrl_pkg::MUL_HI_SS) || (op == rv32_ctrl_pkg::MUL_HI_SU);
    assign b_signed = (op == rv32_ctrl_pkg::MUL_HI_SS);

    // One extra bit lets a single signed multiplier cover all variants
    assign a_ext = {a_signed & a[`RV32_XLEN-1], a};
    assign b_ext = {b_signed & b[`RV32_XLEN-1], b};

    assign product = $signed(a_ext) * $signed(b_ext);

    always_comb begin
        if (op == rv32_ctrl_pkg::MUL_LO) begin
            result = product[`RV32_XLEN-1:0];
        end else begin
            result = product[2*`RV32_XLEN-1:`RV32_XLEN];
        end
    end

endmodule

// File: hw/rv32_branch_unit.sv
`timescale 1ns/10ps

module rv32_branch_unit (
    input  rv32_types_pkg::rv32_word  a,
    input  rv32_types_pkg::rv32_word  b,
    input  rv32_ctrl_pkg::branch_op_t op,
    output logic                      do_branch
);

    always_comb begin
        case (op)
            rv32_ctrl_pkg::BR_EQ:     do_branch = (a == b);
            rv32_ctrl_pkg::BR_NE:     do_branch = (a != b);
            rv32_ctrl_pkg::BR_LT:     do_branch = ($signed(a) < $signed(b));
            rv32_ctrl_pkg::BR_GE:     do_branch = ($signed(a) >= $signed(b));
            rv32_ctrl_pkg::BR_LTU:    do_branch = (a < b);
            rv32_ctrl_pkg::BR_GEU:    do_branch = (a >= b);
            // jal and jalr
            rv32_ctrl_pkg::BR_ALWAYS: do_branch = 1'b1;
            default:                  do_branch = 1'b0;
        endcase
    end

endmodule

// File: hw/rv32_exec_result_stage.sv
`timescale 1ns/10ps
`include "rv32_params.svh"

module rv32_exec_result_stage (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      stop,
    input  rv32_types_pkg::rv32_instr instr,
    input  rv32_types_pkg::rv32_word  pc,
    input  rv32_types_pkg::rv32_word  rs2_data,
    input  rv32_types_pkg::rv32_word  alu_result,
    input  rv32_types_pkg::rv32_word  mul_result,
    input  rv32_ctrl_pkg::wb_src_t    wb_src,
    output rv32_types_pkg::rv32_instr mem_instr,
    output rv32_types_pkg::rv32_word  mem_pc,
    output rv32_types_pkg::rv32_word  mem_wb_result,
    output rv32_types_pkg::rv32_word  mem_addr,
    output rv32_ctrl_pkg::wb_src_t    mem_wb_src
);

    rv32_types_pkg::rv32_word wb_value;

    // Stores carry rs2 in the result slot for the memory stage
    always_comb begin
        case (wb_src)
            rv32_ctrl_pkg::WB_PC4:      wb_value = pc + 32'd4;
            rv32_ctrl_pkg::WB_INT_ALU:  wb_value = alu_result;
            rv32_ctrl_pkg::WB_STORE:    wb_value = rs2_data;
            rv32_ctrl_pkg::WB_MUL_UNIT: wb_value = mul_result;
            default:                    wb_value = '0;
        endcase
    end

    // Execute/memory register, frozen while stop is high
    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_instr     <= `RV32_NOP;
            mem_pc        <= '0;
            mem_wb_src    <= rv32_ctrl_pkg::WB_NONE;
            mem_wb_result <= '0;
            mem_addr      <= '0;
        end else if (!stop) begin
            mem_instr     <= instr;
            mem_pc        <= pc;
            mem_wb_src    <= wb_src;
            mem_wb_result <= wb_value;
            mem_addr      <= alu_result;
        end
    end

    // Stall level and write-back select must be driven once out of reset
    a_ctrl_known: assert property (@(posedge clk) disable iff (!resetn)
        !$isunknown(stop) && !$isunknown(wb_src));

    // A stalled edge leaves the whole register untouched
    a_stall_holds: assert property (@(posedge clk) disable iff (!resetn)
        stop |=> $stable(mem_instr) && $stable(mem_pc) && $stable(mem_wb_src)
                 && $stable(mem_wb_result) && $stable(mem_addr));

endmodule

// File: hw/rv32_exec_stage.sv
`timescale 1ns/10ps

module rv32_exec_stage (
    input  logic                       clk,
    input  logic                       resetn,
    input  rv32_types_pkg::rv32_instr  instr,
    input  rv32_types_pkg::rv32_word   pc,
    input  rv32_types_pkg::rv32_word   reg_data1,
    input  rv32_types_pkg::rv32_word   reg_data2,
    input  rv32_ctrl_pkg::bypass_sel_t bypass_rs1,
    input  rv32_ctrl_pkg::bypass_sel_t bypass_rs2,
    input  rv32_ctrl_pkg::imm_type_t   imm_type,
    input  rv32_ctrl_pkg::alu_in_t     alu_in1,
    input  rv32_ctrl_pkg::alu_in_t     alu_in2,
    input  rv32_ctrl_pkg::alu_op_t     alu_op,
    input  rv32_ctrl_pkg::branch_op_t  branch_op,
    input  rv32_ctrl_pkg::wb_src_t     wb_src,
    input  rv32_types_pkg::rv32_word   wb_bypass,
    input  logic                       stop,
    output logic                       do_jump,
    output rv32_types_pkg::rv32_word   jump_addr,
    output rv32_types_pkg::rv32_instr  mem_instr,
    output rv32_types_pkg::rv32_word   mem_pc,
    output rv32_ctrl_pkg::wb_src_t     mem_wb_src,
    output rv32_types_pkg::rv32_word   mem_wb_result,
    output rv32_types_pkg::rv32_word   mem_addr
);

    rv32_types_pkg::rv32_word op_rs1;
    rv32_types_pkg::rv32_word op_rs2;
    rv32_types_pkg::rv32_word alu_a;
    rv32_types_pkg::rv32_word alu_b;
    rv32_types_pkg::rv32_word alu_result;
    rv32_types_pkg::rv32_word mul_result;
    rv32_ctrl_pkg::mul_op_t   mul_op;

    // mul, mulh, mulhsu, mulhu differ only in funct3[1:0]
    assign mul_op = rv32_ctrl_pkg::mul_op_t'(instr[13:12]);

    // Branch target comes from the ALU, pc plus the B or J immediate
    assign jump_addr = alu_result;

    rv32_operand_stage operand_stage (
        .instr(instr), .pc(pc),
        .reg_data1(reg_data1), .reg_data2(reg_data2),
        .exec_bypass(mem_wb_result), .wb_bypass(wb_bypass),
        .bypass_rs1(bypass_rs1), .bypass_rs2(bypass_rs2),
        .imm_type(imm_type),
        .alu_in1(alu_in1), .alu_in2(alu_in2),
        .op_rs1(op_rs1), .op_rs2(op_rs2),
        .alu_a(alu_a), .alu_b(alu_b)
    );

    rv32_int_alu int_alu (
        .a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result)
    );

    rv32_mul_unit mul_unit (
        .a(op_rs1), .b(op_rs2), .op(mul_op), .result(mul_result)
    );

    rv32_branch_unit branch_unit (
        .a(op_rs1), .b(op_rs2), .op(branch_op), .do_branch(do_jump)
    );

    rv32_exec_result_stage result_stage (
        .clk(clk), .resetn(resetn), .stop(stop),
        .instr(instr), .pc(pc), .rs2_data(op_rs2),
        .alu_result(alu_result), .mul_result(mul_result), .wb_src(wb_src),
        .mem_instr(mem_instr), .mem_pc(mem_pc),
        .mem_wb_result(mem_wb_result), .mem_addr(mem_addr),
        .mem_wb_src(mem_wb_src)
    );

endmodule

// File: bench/rv32_exec_stage_tb.sv
`timescale 1ns/10ps
`include "rv32_params.svh"

module rv32_exec_stage_tb;

    localparam int RUNS = 4;
    localparam int STALL_CYCLES = 5;
    // Reset, then alu, imm and branch runs, mul corners plus runs, bypass and stall
    localparam int TEST_CYCLES = 17 + 30 * RUNS + 4 * (16 + RUNS) + 4 + STALL_CYCLES;

    logic                       clk;
    logic                       resetn;
    logic                       stop;
    logic                       do_jump;
    rv32_types_pkg::rv32_instr  instr;
    rv32_types_pkg::rv32_instr  mem_instr;
    rv32_types_pkg::rv32_word   pc, reg_data1, reg_data2, wb_bypass;
    rv32_types_pkg::rv32_word   jump_addr, mem_pc, mem_wb_result, mem_addr;
    rv32_ctrl_pkg::bypass_sel_t bypass_rs1, bypass_rs2;
    rv32_ctrl_pkg::imm_type_t   imm_type;
    rv32_ctrl_pkg::alu_in_t     alu_in1, alu_in2;
    rv32_ctrl_pkg::alu_op_t     alu_op;
    rv32_ctrl_pkg::branch_op_t  branch_op;
    rv32_ctrl_pkg::wb_src_t     wb_src, mem_wb_src;
    logic [31:0]                lfsr_state = 32'hfb80;

    rv32_exec_stage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #((TEST_CYCLES + 100) * 100);
        $display("Watchdog expired, tests still running after %0d cycles", TEST_CYCLES + 100);
        $display("Test FAILED");
        $fatal(1, "Simulation timeout");
    end

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        for (int i = 0; i < 32; i++) begin
            // Galois step, taps of x^32 + x^22 + x^2 + x + 1
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic logic [31:0] alu_model(input logic [31:0] a, b,
                                              input rv32_ctrl_pkg::alu_op_t op);
        logic [31:0] sign_fill;
        sign_fill = a[31] ? ~(32'hffffffff >> b[4:0]) : 32'h0;
        case (op)
            rv32_ctrl_pkg::ALU_ADD:  return a + b;
            rv32_ctrl_pkg::ALU_SUB:  return a + ~b + 32'd1;
            rv32_ctrl_pkg::ALU_AND:  return a & b;
            rv32_ctrl_pkg::ALU_OR:   return a | b;
            rv32_ctrl_pkg::ALU_XOR:  return a ^ b;
            rv32_ctrl_pkg::ALU_SLL:  return a << b[4:0];
            rv32_ctrl_pkg::ALU_SRL:  return a >> b[4:0];
            rv32_ctrl_pkg::ALU_SRA:  return (a >> b[4:0]) | sign_fill;
            // Signed order is unsigned order with both sign bits flipped
            rv32_ctrl_pkg::ALU_SLT:  return {31'b0, (a ^ 32'h80000000) < (b ^ 32'h80000000)};
            rv32_ctrl_pkg::ALU_SLTU: return {31'b0, a < b};
            default:                 return 32'h0;
        endcase
    endfunction

    // Field moved to the top of the word, then shifted down with its sign
    function automatic logic [31:0] decode_imm(input logic [31:0] w,
                                               input rv32_ctrl_pkg::imm_type_t t);
        logic [31:0] top;
        int          sh;
        case (t)
            rv32_ctrl_pkg::IMM_I: top = {w[31:20], 20'b0};
            rv32_ctrl_pkg::IMM_S: top = {w[31:25], w[11:7], 20'b0};
            rv32_ctrl_pkg::IMM_B: top = {w[31], w[7], w[30:25], w[11:8], 1'b0, 19'b0};
            rv32_ctrl_pkg::IMM_U: top = {w[31:12], 12'b0};
            rv32_ctrl_pkg::IMM_J: top = {w[31], w[19:12], w[20], w[30:21], 1'b0, 11'b0};
            default:              top = 32'h0;
        endcase
        sh = (t == rv32_ctrl_pkg::IMM_B) ? 19 : (t == rv32_ctrl_pkg::IMM_J) ? 11 :
             (t == rv32_ctrl_pkg::IMM_U) ? 0 : 20;
        return 32'($signed(top) >>> sh);
    endfunction

    function automatic logic [31:0] mul_model(input logic [31:0] a, b, input int m);
        logic [63:0] ax;
        logic [63:0] bx;
        logic [63:0] p;
        // mulh and mulhsu take rs1 as signed, only mulh takes rs2 as signed
        ax = {((m == 1 || m == 2) ? {32{a[31]}} : 32'h0), a};
        bx = {((m == 1) ? {32{b[31]}} : 32'h0), b};
        p  = ax * bx;
        return (m == 0) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic branch_taken(input logic [31:0] a, b,
                                          input rv32_ctrl_pkg::branch_op_t op);
        logic lt;
        lt = (a ^ 32'h80000000) < (b ^ 32'h80000000);
        case (op)
            rv32_ctrl_pkg::BR_EQ:     return a == b;
            rv32_ctrl_pkg::BR_NE:     return a != b;
            rv32_ctrl_pkg::BR_LT:     return lt;
            rv32_ctrl_pkg::BR_GE:     return !lt;
            rv32_ctrl_pkg::BR_LTU:    return a < b;
            rv32_ctrl_pkg::BR_GEU:    return !(a < b);
            rv32_ctrl_pkg::BR_ALWAYS: return 1'b1;
            default:                  return 1'b0;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %08h, actual %08h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    // Registered outputs of an ALU instruction, mem_addr follows the result
    task automatic check_regs(input string name, input logic [31:0] ins, pcv, res);
        check({name, " mem_instr"}, ins, mem_instr);
        check({name, " mem_pc"}, pcv, mem_pc);
        check({name, " mem_wb_src"}, 32'(wb_src), 32'(mem_wb_src));
        check({name, " mem_wb_result"}, res, mem_wb_result);
        check({name, " mem_addr"}, res, mem_addr);
    endtask

    // Next rising edge plus the drive offset
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic reset_values();
        check("reset_values mem_instr", `RV32_NOP, mem_instr);
        check("reset_values mem_pc", 32'h0, mem_pc);
        check("reset_values mem_wb_src", 32'(rv32_ctrl_pkg::WB_NONE), 32'(mem_wb_src));
        check("reset_values mem_wb_result", 32'h0, mem_wb_result);
        check("reset_values mem_addr", 32'h0, mem_addr);
        check("reset_values do_jump", 32'h0, {31'b0, do_jump});
    endtask

    task automatic alu_ops();
        logic [31:0] exp;
        for (int op = 0; op < 10; op++) begin
            for (int k = 0; k < RUNS; k++) begin
                alu_op    = rv32_ctrl_pkg::alu_op_t'(op);
                reg_data1 = rand_word();
                reg_data2 = rand_word();
                exp       = alu_model(reg_data1, reg_data2, alu_op);
                step();
                check_regs("alu_ops", instr, pc, exp);
            end
        end
    endtask

    task automatic imm_formats();
        logic [31:0] exp;
        alu_in2 = rv32_ctrl_pkg::ALU_IN_IMM;
        alu_op  = rv32_ctrl_pkg::ALU_ADD;
        for (int k = 0; k < RUNS; k++) begin
            instr = rand_word();
            pc    = rand_word() & ~32'h3;
            for (int f = 0; f < 6; f++) begin
                for (int rel = 0; rel < 2; rel++) begin
                    imm_type = rv32_ctrl_pkg::imm_type_t'(f);
                    alu_in1  = rel ? rv32_ctrl_pkg::ALU_IN_PC : rv32_ctrl_pkg::ALU_IN_ZERO;
                    exp      = (rel ? pc : 32'h0) + decode_imm(instr, imm_type);
                    step();
                    check_regs("imm_formats", instr, pc, exp);
                end
            end
        end
    endtask

    task automatic mul_variants();
        logic [31:0] corners [4];
        logic [31:0] exp;
        corners = '{32'h0, 32'h1, 32'h80000000, 32'hffffffff};
        wb_src  = rv32_ctrl_pkg::WB_MUL_UNIT;
        for (int m = 0; m < 4; m++) begin
            // R-type with funct7 of the M extension, funct3 picks the variant
            instr = 32'h02000033 | (m << 12);
            for (int i = 0; i < 16 + RUNS; i++) begin
                reg_data1 = (i < 16) ? corners[2'(i / 4)] : rand_word();
                reg_data2 = (i < 16) ? corners[2'(i % 4)] : rand_word();
                exp       = mul_model(reg_data1, reg_data2, m);
                step();
                check("mul_variants mem_wb_result", exp, mem_wb_result);
            end
        end
    endtask

    task automatic branches();
        logic [31:0] target;
        logic        taken;
        imm_type = rv32_ctrl_pkg::IMM_B;
        alu_in1  = rv32_ctrl_pkg::ALU_IN_PC;
        alu_in2  = rv32_ctrl_pkg::ALU_IN_IMM;
        wb_src   = rv32_ctrl_pkg::WB_PC4;
        for (int op = 0; op < 8; op++) begin
            for (int k = 0; k < RUNS; k++) begin
                branch_op = rv32_ctrl_pkg::branch_op_t'(op);
                instr     = rand_word();
                pc        = rand_word() & ~32'h3;
                reg_data1 = rand_word();
                // Equal pair, opposite signs, then random
                reg_data2 = (k == 0) ? reg_data1 :
                            (k == 1) ? (reg_data1 ^ 32'h80000000) : rand_word();
                target    = pc + decode_imm(instr, rv32_ctrl_pkg::IMM_B);
                taken     = branch_taken(reg_data1, reg_data2, branch_op);
                #10;
                check("branches do_jump", {31'b0, taken}, {31'b0, do_jump});
                check("branches jump_addr", target, jump_addr);
                step();
                check("branches mem_wb_result", pc + 32'd4, mem_wb_result);
                check("branches mem_addr", target, mem_addr);
            end
        end
        branch_op = rv32_ctrl_pkg::BR_NONE;
    endtask

    task automatic bypass_and_stall();
        logic [31:0] res;
        logic [31:0] held_instr;
        logic [31:0] held_pc;
        logic [31:0] held_src;
        alu_in1   = rv32_ctrl_pkg::ALU_IN_REG_1;
        alu_in2   = rv32_ctrl_pkg::ALU_IN_REG_2;
        alu_op    = rv32_ctrl_pkg::ALU_ADD;
        wb_src    = rv32_ctrl_pkg::WB_INT_ALU;
        reg_data1 = rand_word();
        reg_data2 = rand_word();
        res       = reg_data1 + reg_data2;
        step();
        check_regs("bypass plain", instr, pc, res);
        // rs1 from the result registered at the last edge
        bypass_rs1 = rv32_ctrl_pkg::BYPASS_EXEC_BUFF;
        reg_data1  = rand_word();
        reg_data2  = rand_word();
        res        = res + reg_data2;
        step();
        check_regs("bypass exec_buff", instr, pc, res);
        bypass_rs1 = rv32_ctrl_pkg::BYPASS_NONE;
        bypass_rs2 = rv32_ctrl_pkg::BYPASS_MEM_BUFF;
        reg_data1  = rand_word();
        reg_data2  = rand_word();
        wb_bypass  = rand_word();
        res        = reg_data1 + wb_bypass;
        step();
        check_regs("bypass mem_buff", instr, pc, res);
        held_instr = instr;
        held_pc    = pc;
        held_src   = 32'(wb_src);
        stop       = 1'b1;
        // Next instruction waiting upstream is a store with rs2 from write-back
        instr      = rand_word();
        pc         = rand_word() & ~32'h3;
        reg_data1  = rand_word();
        wb_src     = rv32_ctrl_pkg::WB_STORE;
        repeat (STALL_CYCLES) begin
            step();
            check("stall hold mem_instr", held_instr, mem_instr);
            check("stall hold mem_pc", held_pc, mem_pc);
            check("stall hold mem_wb_src", held_src, 32'(mem_wb_src));
            check("stall hold mem_wb_result", res, mem_wb_result);
            check("stall hold mem_addr", res, mem_addr);
        end
        stop = 1'b0;
        step();
        // Store data is rs2, the address is the ALU sum
        check("stall release mem_instr", instr, mem_instr);
        check("stall release mem_pc", pc, mem_pc);
        check("stall release mem_wb_src", 32'(rv32_ctrl_pkg::WB_STORE), 32'(mem_wb_src));
        check("stall release mem_wb_result", wb_bypass, mem_wb_result);
        check("stall release mem_addr", reg_data1 + wb_bypass, mem_addr);
    endtask

    initial begin
        resetn     = 1'b0;
        stop       = 1'b0;
        instr      = `RV32_NOP;
        pc         = 32'h0;
        reg_data1  = 32'h0;
        reg_data2  = 32'h0;
        wb_bypass  = 32'h0;
        bypass_rs1 = rv32_ctrl_pkg::BYPASS_NONE;
        bypass_rs2 = rv32_ctrl_pkg::BYPASS_NONE;
        imm_type   = rv32_ctrl_pkg::IMM_R;
        alu_in1    = rv32_ctrl_pkg::ALU_IN_REG_1;
        alu_in2    = rv32_ctrl_pkg::ALU_IN_REG_2;
        alu_op     = rv32_ctrl_pkg::ALU_ADD;
        branch_op  = rv32_ctrl_pkg::BR_NONE;
        wb_src     = rv32_ctrl_pkg::WB_INT_ALU;
        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b1;
        reset_values();
        alu_ops();
        imm_formats();
        mul_variants();
        branches();
        bypass_and_stall();
        $display("Test OK");
        $finish;
    end

endmodule

// File: sources.f
+incdir+hw
hw/rv32_types_pkg.sv
hw/rv32_ctrl_pkg.sv
hw/rv32_operand_stage.sv
hw/rv32_int_alu.sv
hw/rv32_mul_unit.sv
hw/rv32_branch_unit.sv
hw/rv32_exec_result_stage.sv
hw/rv32_exec_stage.sv
bench/rv32_exec_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --assert -f sources.f --top-module rv32_exec_stage_tb \
    -o rv32_exec_stage_sim \
    && ./obj_dir/rv32_exec_stage_sim \
    || { echo "Simulation failed"; exit 1; }
